//--- rtl/audio_config.svh
//##########################################################################
// Audio engine configuration
// Channel count, bit clock divider and memory address width
//##########################################################################
`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

// Voice channels, also the width of the channel mask
`define AUDIO_NUM_CHANNELS 4

// aclk cycles per half bit clock period
`define AUDIO_BCLK_DIV 4

// Memory byte address width
`define AUDIO_ADDR_W 32

`endif

//--- rtl/audioRegPkg.sv
//##########################################################################
// Audio register package
// Register map and register field types of the CPU write port
//##########################################################################
`default_nettype none

package audioRegPkg;

    // Register index, taken from awaddr[5:2]
    typedef enum logic [3:0] {
        regStartAddr     = 4'd1,
        regSampleCount   = 4'd2,
        regLoopStart     = 4'd3,
        regLoopEnd       = 4'd4,
        regPosition      = 4'd5,
        regVolume        = 4'd7,
        regLooping       = 4'd8,
        regPlaying       = 4'd9,
        regMono          = 4'd10,
        regRight         = 4'd11,
        regGlobalVolume  = 4'd12,
        regChannelSelect = 4'd13
    } regSel_e;

    // Counted in 16-bit samples
    typedef logic [23:0] sampleIdx_t;

    // Unsigned gain, 128 is unity
    typedef logic [7:0] volume_t;

endpackage

`default_nettype wire

//--- rtl/audioSamplePkg.sv
//##########################################################################
// Audio sample package
// Sample and accumulator types, fetch FSM states
//##########################################################################
`default_nettype none

package audioSamplePkg;

    typedef logic signed [15:0] sample_t;

    // Wide enough for all channels at full master volume
    typedef logic signed [31:0] mixAcc_t;

    typedef enum logic [1:0] {
        fetchIdle,
        fetchAddress,
        fetchData,
        fetchDeliver
    } fetchState_e;

endpackage

`default_nettype wire

//--- rtl/regInterface.sv
//##########################################################################
// Register interface
// AXI-Lite write slave, turns writes into channel strobes and master volume
//##########################################################################
`default_nettype none
`include "audio_config.svh"

module regInterface (
    input  wire logic                          i_aclk,
    input  wire logic                          i_aresetn,
    input  wire logic [`AUDIO_ADDR_W-1:0]      i_awaddr,
    input  wire logic                          i_awvalid,
    output logic                               o_awready,
    input  wire logic [31:0]                   i_wdata,
    input  wire logic                          i_wvalid,
    output logic                               o_wready,
    output logic [1:0]                         o_bresp,
    output logic                               o_bvalid,
    input  wire logic                          i_bready,
    output logic [`AUDIO_NUM_CHANNELS-1:0]     o_regWrite,
    output audioRegPkg::regSel_e               o_regSel,
    output logic [31:0]                        o_regData,
    output audioRegPkg::volume_t               o_masterVolume
);
    import audioRegPkg::*;

    logic [`AUDIO_NUM_CHANNELS-1:0] channelMask;
    regSel_e beatSel;
    logic accept;

    // Address and data must arrive together
    assign accept    = i_awvalid && i_wvalid && !o_bvalid;
    assign o_awready = !o_bvalid;
    assign o_wready  = !o_bvalid;
    assign o_bresp   = 2'b00;
    assign beatSel   = regSel_e'(i_awaddr[5:2]);

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            o_bvalid       <= 1'b0;
            o_regWrite     <= '0;
            channelMask    <= '0;
            o_masterVolume <= 8'd128;
        end else begin
            o_regWrite <= '0;
            if (o_bvalid && i_bready) begin
                o_bvalid <= 1'b0;
            end
            if (accept) begin
                o_bvalid <= 1'b1;
                case (beatSel)
                    regChannelSelect: channelMask <= i_wdata[`AUDIO_NUM_CHANNELS-1:0];
                    regGlobalVolume:  o_masterVolume <= i_wdata[7:0];
                    default:          o_regWrite <= channelMask;
                endcase
            end
        end
    end

    // Index and data that go with the strobe
    always_ff @(posedge i_aclk) begin
        if (accept) begin
            o_regSel  <= beatSel;
            o_regData <= i_wdata;
        end
    end

    bvalidHeld: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        o_bvalid && !i_bready |=> o_bvalid);

endmodule

`default_nettype wire

//--- rtl/voiceChannel.sv
//##########################################################################
// Voice channel
// Settings, play position with loop and stop, volume scaling of the sample
//##########################################################################
`default_nettype none

module voiceChannel (
    input  wire logic                      i_aclk,
    input  wire logic                      i_aresetn,
    input  wire logic                      i_regWrite,
    input  wire audioRegPkg::regSel_e      i_regSel,
    input  wire logic [31:0]               i_regData,
    input  wire logic                      i_sampleReady,
    input  wire audioSamplePkg::sample_t   i_sample,
    output logic                           o_playing,
    output logic                           o_mono,
    output logic                           o_right,
    output audioRegPkg::sampleIdx_t        o_nextIndex,
    output audioSamplePkg::sample_t        o_scaled
);
    import audioRegPkg::*;
    import audioSamplePkg::*;

    sampleIdx_t startAddr;
    sampleIdx_t sampleCount;
    sampleIdx_t loopStart;
    sampleIdx_t loopEnd;
    sampleIdx_t position;
    sampleIdx_t nextPos;
    volume_t volume;
    logic looping;
    sample_t sample;
    logic signed [24:0] product;

    assign nextPos     = position + 24'd1;
    assign o_nextIndex = startAddr + position;
    assign product     = sample * $signed({1'b0, volume});
    assign o_scaled    = o_playing ? sample_t'(product >>> 7) : '0;

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            o_playing <= 1'b0;
            looping   <= 1'b0;
            o_mono    <= 1'b0;
            o_right   <= 1'b0;
            sample    <= '0;
        end else begin
            if (i_sampleReady) begin
                sample <= i_sample;
                // One-shot end
                if (!looping && nextPos >= sampleCount) begin
                    o_playing <= 1'b0;
                end
            end
            if (i_regWrite) begin
                case (i_regSel)
                    regLooping: looping   <= i_regData[0];
                    regPlaying: o_playing <= i_regData[0];
                    regMono:    o_mono    <= i_regData[0];
                    regRight:   o_right   <= i_regData[0];
                    default:    ;
                endcase
            end
        end
    end

    // Register writes win over the position advance
    always_ff @(posedge i_aclk) begin
        if (i_sampleReady) begin
            if (looping && nextPos >= loopEnd) begin
                position <= loopStart;
            end else begin
                position <= nextPos;
            end
        end
        if (i_regWrite) begin
            case (i_regSel)
                regStartAddr:   startAddr   <= i_regData[23:0];
                regSampleCount: sampleCount <= i_regData[23:0];
                regLoopStart:   loopStart   <= i_regData[23:0];
                regLoopEnd:     loopEnd     <= i_regData[23:0];
                regPosition:    position    <= i_regData[23:0];
                regVolume:      volume      <= i_regData[7:0];
                default:        ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/sampleFetcher.sv
//##########################################################################
// Sample fetcher
// Round-robin AXI-Lite read master, one sample per playing channel per frame
//##########################################################################
`default_nettype none
`include "audio_config.svh"

module sampleFetcher (
    input  wire logic                          i_aclk,
    input  wire logic                          i_aresetn,
    input  wire logic                          i_frameTick,
    input  wire logic [`AUDIO_NUM_CHANNELS-1:0] i_playing,
    input  wire audioRegPkg::sampleIdx_t       i_nextIndex [`AUDIO_NUM_CHANNELS],
    output logic [`AUDIO_ADDR_W-1:0]           o_araddr,
    output logic                               o_arvalid,
    input  wire logic                          i_arready,
    input  wire logic [31:0]                   i_rdata,
    input  wire logic                          i_rvalid,
    output logic                               o_rready,
    output logic [`AUDIO_NUM_CHANNELS-1:0]     o_sampleReady,
    output audioSamplePkg::sample_t            o_sample
);
    import audioRegPkg::*;
    import audioSamplePkg::*;

    localparam int chanW = $clog2(`AUDIO_NUM_CHANNELS);
    localparam logic [chanW-1:0] lastChan = chanW'(`AUDIO_NUM_CHANNELS - 1);

    fetchState_e state;
    logic [chanW-1:0] chan;
    logic oddHalf;
    sampleIdx_t index;

    assign index    = i_nextIndex[chan];
    assign o_rready = (state == fetchData);

    always_comb begin
        o_sampleReady = '0;
        if (state == fetchDeliver) begin
            o_sampleReady[chan] = 1'b1;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            state     <= fetchIdle;
            chan      <= '0;
            o_arvalid <= 1'b0;
        end else begin
            case (state)
                fetchIdle: begin
                    if (i_frameTick) begin
                        chan  <= '0;
                        state <= fetchAddress;
                    end
                end
                fetchAddress: begin
                    if (o_arvalid) begin
                        if (i_arready) begin
                            o_arvalid <= 1'b0;
                            state     <= fetchData;
                        end
                    end else if (i_playing[chan]) begin
                        o_arvalid <= 1'b1;
                    end else begin
                        // Stopped channel costs one cycle
                        state <= (chan == lastChan) ? fetchIdle : fetchAddress;
                        chan  <= chan + 1'b1;
                    end
                end
                fetchData: begin
                    if (i_rvalid) begin
                        state <= fetchDeliver;
                    end
                end
                fetchDeliver: begin
                    state <= (chan == lastChan) ? fetchIdle : fetchAddress;
                    chan  <= chan + 1'b1;
                end
                default: state <= fetchIdle;
            endcase
        end
    end

    // Word address of the sample, halfword picked by the low index bit
    always_ff @(posedge i_aclk) begin
        if (state == fetchAddress && !o_arvalid) begin
            o_araddr <= `AUDIO_ADDR_W'({index[23:1], 2'b00});
            oddHalf  <= index[0];
        end
        if (o_rready && i_rvalid) begin
            o_sample <= oddHalf ? i_rdata[31:16] : i_rdata[15:0];
        end
    end

    roundInFrame: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        i_frameTick |-> state == fetchIdle);

    araddrStable: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr));

endmodule

`default_nettype wire

//--- rtl/stereoMixer.sv
//##########################################################################
// Stereo mixer
// Pan routing, summation, master volume and 16-bit saturation
//##########################################################################
`default_nettype none
`include "audio_config.svh"

module stereoMixer (
    input  wire logic                          i_aclk,
    input  wire logic                          i_aresetn,
    input  wire logic                          i_frameTick,
    input  wire audioSamplePkg::sample_t       i_scaled [`AUDIO_NUM_CHANNELS],
    input  wire logic [`AUDIO_NUM_CHANNELS-1:0] i_mono,
    input  wire logic [`AUDIO_NUM_CHANNELS-1:0] i_right,
    input  wire audioRegPkg::volume_t          i_masterVolume,
    output audioSamplePkg::sample_t            o_left,
    output audioSamplePkg::sample_t            o_right
);
    import audioSamplePkg::*;

    mixAcc_t leftSum;
    mixAcc_t rightSum;
    mixAcc_t leftAmp;
    mixAcc_t rightAmp;

    function automatic sample_t saturate(input mixAcc_t value);
        if (value > 32'sd32767) begin
            return 16'sh7fff;
        end else if (value < -32'sd32768) begin
            return 16'sh8000;
        end
        return value[15:0];
    endfunction

    // Mono goes to both sides
    always_comb begin
        leftSum  = '0;
        rightSum = '0;
        for (int ch = 0; ch < `AUDIO_NUM_CHANNELS; ch++) begin
            if (i_mono[ch] || !i_right[ch]) begin
                leftSum = leftSum + i_scaled[ch];
            end
            if (i_mono[ch] || i_right[ch]) begin
                rightSum = rightSum + i_scaled[ch];
            end
        end
    end

    assign leftAmp  = (leftSum * $signed({1'b0, i_masterVolume})) >>> 7;
    assign rightAmp = (rightSum * $signed({1'b0, i_masterVolume})) >>> 7;

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            o_left  <= '0;
            o_right <= '0;
        end else if (i_frameTick) begin
            o_left  <= saturate(leftAmp);
            o_right <= saturate(rightAmp);
        end
    end

endmodule

`default_nettype wire

//--- rtl/i2sSerializer.sv
//##########################################################################
// I2S serializer
// Bit clock and word select from aclk, frame tick, MSB-first shift out
//##########################################################################
`default_nettype none
`include "audio_config.svh"

module i2sSerializer (
    input  wire logic                      i_aclk,
    input  wire logic                      i_aresetn,
    input  wire audioSamplePkg::sample_t   i_left,
    input  wire audioSamplePkg::sample_t   i_right,
    output logic                           o_frameTick,
    output logic                           o_bclk,
    output logic                           o_lrclk,
    output logic                           o_dout
);
    localparam int divW = $clog2(`AUDIO_BCLK_DIV);
    localparam logic [divW-1:0] divLast = divW'(`AUDIO_BCLK_DIV - 1);

    logic [divW-1:0] divCount;
    logic [4:0] slot;
    logic [4:0] slotNext;
    logic bclkFall;
    logic loadPending;
    logic [31:0] shiftReg;

    assign bclkFall = (divCount == divLast) && o_bclk;
    assign slotNext = slot + 5'd1;

    always_ff @(posedge i_aclk) begin
        if (!i_aresetn) begin
            divCount    <= '0;
            slot        <= '0;
            o_bclk      <= 1'b0;
            o_lrclk     <= 1'b0;
            o_dout      <= 1'b0;
            o_frameTick <= 1'b0;
            loadPending <= 1'b0;
            shiftReg    <= '0;
        end else begin
            divCount    <= (divCount == divLast) ? '0 : divCount + 1'b1;
            // Tick with the falling word select, load once the mixer has the frame
            o_frameTick <= bclkFall && (slotNext == 5'd0);
            loadPending <= o_frameTick;
            if (divCount == divLast) begin
                o_bclk <= !o_bclk;
            end
            if (loadPending) begin
                shiftReg <= {i_left, i_right};
            end
            if (bclkFall) begin
                slot     <= slotNext;
                o_lrclk  <= slotNext[4];
                o_dout   <= shiftReg[31];
                shiftReg <= {shiftReg[30:0], 1'b0};
            end
        end
    end

    wsOnFall: assert property (@(posedge i_aclk) disable iff (!i_aresetn)
        $changed(o_lrclk) |-> $fell(o_bclk));

endmodule

`default_nettype wire

//--- rtl/audioSystem.sv
//##########################################################################
// Wavetable audio engine top level
//##########################################################################
`default_nettype none
`include "audio_config.svh"

module audioSystem (
    input  wire logic                          i_aclk,
    input  wire logic                          i_aresetn,
    // CPU write port
    input  wire logic [`AUDIO_ADDR_W-1:0]      i_awaddr,
    input  wire logic                          i_awvalid,
    output logic                               o_awready,
    input  wire logic [31:0]                   i_wdata,
    input  wire logic                          i_wvalid,
    output logic                               o_wready,
    output logic [1:0]                         o_bresp,
    output logic                               o_bvalid,
    input  wire logic                          i_bready,
    // Memory read port
    output logic [`AUDIO_ADDR_W-1:0]           o_araddr,
    output logic                               o_arvalid,
    input  wire logic                          i_arready,
    input  wire logic [31:0]                   i_rdata,
    input  wire logic                          i_rvalid,
    output logic                               o_rready,
    // I2S
    output logic                               o_audioBclk,
    output logic                               o_audioLrclk,
    output logic                               o_audioDout
);
    import audioRegPkg::*;
    import audioSamplePkg::*;

    logic [`AUDIO_NUM_CHANNELS-1:0] regWrite;
    regSel_e regSel;
    logic [31:0] regData;
    volume_t masterVolume;
    logic [`AUDIO_NUM_CHANNELS-1:0] sampleReady;
    logic [`AUDIO_NUM_CHANNELS-1:0] playing;
    logic [`AUDIO_NUM_CHANNELS-1:0] mono;
    logic [`AUDIO_NUM_CHANNELS-1:0] right;
    sampleIdx_t nextIndex [`AUDIO_NUM_CHANNELS];
    sample_t scaled [`AUDIO_NUM_CHANNELS];
    sample_t fetchedSample;
    sample_t mixLeft;
    sample_t mixRight;
    logic frameTick;

    regInterface uRegs (
        .i_aclk         (i_aclk),
        .i_aresetn      (i_aresetn),
        .i_awaddr       (i_awaddr),
        .i_awvalid      (i_awvalid),
        .o_awready      (o_awready),
        .i_wdata        (i_wdata),
        .i_wvalid       (i_wvalid),
        .o_wready       (o_wready),
        .o_bresp        (o_bresp),
        .o_bvalid       (o_bvalid),
        .i_bready       (i_bready),
        .o_regWrite     (regWrite),
        .o_regSel       (regSel),
        .o_regData      (regData),
        .o_masterVolume (masterVolume)
    );

    for (genvar ch = 0; ch < `AUDIO_NUM_CHANNELS; ch++) begin : gChannel
        voiceChannel uVoice (
            .i_aclk        (i_aclk),
            .i_aresetn     (i_aresetn),
            .i_regWrite    (regWrite[ch]),
            .i_regSel      (regSel),
            .i_regData     (regData),
            .i_sampleReady (sampleReady[ch]),
            .i_sample      (fetchedSample),
            .o_playing     (playing[ch]),
            .o_mono        (mono[ch]),
            .o_right       (right[ch]),
            .o_nextIndex   (nextIndex[ch]),
            .o_scaled      (scaled[ch])
        );
    end

    sampleFetcher uFetch (
        .i_aclk        (i_aclk),
        .i_aresetn     (i_aresetn),
        .i_frameTick   (frameTick),
        .i_playing     (playing),
        .i_nextIndex   (nextIndex),
        .o_araddr      (o_araddr),
        .o_arvalid     (o_arvalid),
        .i_arready     (i_arready),
        .i_rdata       (i_rdata),
        .i_rvalid      (i_rvalid),
        .o_rready      (o_rready),
        .o_sampleReady (sampleReady),
        .o_sample      (fetchedSample)
    );

    stereoMixer uMixer (
        .i_aclk         (i_aclk),
        .i_aresetn      (i_aresetn),
        .i_frameTick    (frameTick),
        .i_scaled       (scaled),
        .i_mono         (mono),
        .i_right        (right),
        .i_masterVolume (masterVolume),
        .o_left         (mixLeft),
        .o_right        (mixRight)
    );

    i2sSerializer uI2s (
        .i_aclk      (i_aclk),
        .i_aresetn   (i_aresetn),
        .i_left      (mixLeft),
        .i_right     (mixRight),
        .o_frameTick (frameTick),
        .o_bclk      (o_audioBclk),
        .o_lrclk     (o_audioLrclk),
        .o_dout      (o_audioDout)
    );

endmodule

`default_nettype wire

//--- sim/tbClock.sv
//##########################################################################
// Testbench clock and reset
// 20 ns aclk, aresetn held low for two cycles
//##########################################################################
`default_nettype none

module tbClock (
    output logic o_aclk,
    output logic o_aresetn
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_aclk = 1'b0;
        forever #10 o_aclk = !o_aclk;
    end

    initial begin
        o_aresetn = 1'b0;
        repeat (2) @(posedge o_aclk);
        #2 o_aresetn = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/tbAudio.sv
//##########################################################################
// Audio engine testbench
// Memory model, I2S decoder, mixing model and directed tests
//##########################################################################
`default_nettype none
`include "audio_config.svh"

module tbAudio;
    timeunit 1ns;
    timeprecision 100ps;
    import audioRegPkg::*;

    // Frames per test, sync and lead frames included
    localparam int testFrames = 5 + (8 + 6 + 11 + 6 + 4 + 12) + 6 * 5;
    localparam int timeoutNs = (testFrames + 20) * 256 * 20;

    logic aclk;
    logic aresetn;
    logic [31:0] awaddr;
    logic awvalid;
    logic awready;
    logic [31:0] wdata;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [31:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic rvalid;
    logic rready;
    logic bclk;
    logic lrclk;
    logic dout;

    logic [31:0] mem [256];
    logic [7:0] addrWord;
    logic [31:0] shiftIn;
    logic [31:0] word;
    logic prevLr;
    logic [31:0] frames [$];
    logic [31:0] expFrames [$];

    // Channel settings as the model sees them
    int chStart [4];
    int chCount [4];
    int chLoopS [4];
    int chLoopE [4];
    int chLoop [4];
    int chVol [4];
    int chMono [4];
    int chRight [4];
    int masterVol;

    tbClock uClock (.o_aclk(aclk), .o_aresetn(aresetn));

    audioSystem DUT (
        .i_aclk       (aclk),
        .i_aresetn    (aresetn),
        .i_awaddr     (awaddr),
        .i_awvalid    (awvalid),
        .o_awready    (awready),
        .i_wdata      (wdata),
        .i_wvalid     (wvalid),
        .o_wready     (wready),
        .o_bresp      (bresp),
        .o_bvalid     (bvalid),
        .i_bready     (bready),
        .o_araddr     (araddr),
        .o_arvalid    (arvalid),
        .i_arready    (arready),
        .i_rdata      (rdata),
        .i_rvalid     (rvalid),
        .o_rready     (rready),
        .o_audioBclk  (bclk),
        .o_audioLrclk (lrclk),
        .o_audioDout  (dout)
    );

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string test, input string what,
                              input logic [31:0] expVal, input logic [31:0] actVal);
        assert (expVal === actVal) else begin
            failRun($sformatf("ERROR %s: %s expected %h actual %h",
                              test, what, expVal, actVal));
        end
    endtask

    function automatic logic signed [15:0] memHalf(input int idx);
        logic [31:0] w;
        w = mem[(idx / 2) % 256];
        return (idx % 2) ? w[31:16] : w[15:0];
    endfunction

    function automatic int saturate(input int v);
        if (v > 32767) begin
            return 32767;
        end else if (v < -32768) begin
            return -32768;
        end
        return v;
    endfunction

    // ########################################################################
    // Memory model, random wait before each beat
    // ########################################################################
    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        @(posedge aresetn);
        forever begin
            @(posedge aclk);
            #2;
            if (arvalid) begin
                repeat ($urandom_range(3, 0)) begin
                    @(posedge aclk);
                    #2;
                end
                arready  = 1'b1;
                addrWord = araddr[9:2];
                @(posedge aclk);
                #2 arready = 1'b0;
                repeat ($urandom_range(3, 0)) begin
                    @(posedge aclk);
                    #2;
                end
                rdata  = mem[addrWord];
                rvalid = 1'b1;
                // Hold the beat until the fetcher takes it
                while (!rready) begin
                    @(posedge aclk);
                    #2;
                end
                @(posedge aclk);
                #2 rvalid = 1'b0;
            end else begin
                checkValue("memoryModel", "rready without a read", 0, rready);
            end
        end
    end

    // I2S decoder, frame complete on the right LSB just after word select falls
    always @(posedge bclk) begin
        word = {shiftIn[30:0], dout};
        shiftIn = word;
        if (!lrclk && prevLr) begin
            frames.push_back(word);
        end
        prevLr = lrclk;
    end

    initial begin
        #(timeoutNs);
        failRun("Timeout: the tests did not finish in the expected time");
    end

    // ########################################################################
    // CPU writes and the channel model
    // ########################################################################
    task automatic cpuWrite(input regSel_e sel, input logic [31:0] data);
        @(posedge aclk);
        #2;
        checkValue("cpuWrite", "awready", 1, awready);
        awaddr  = {26'd0, sel, 2'b00};
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(posedge aclk);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        checkValue("cpuWrite", "bvalid", 1, bvalid);
        checkValue("cpuWrite", "bresp", 0, bresp);
        checkValue("cpuWrite", "ready while pending", 0, {awready, wready});
        bready = 1'b1;
        @(posedge aclk);
        #2 bready = 1'b0;
        checkValue("cpuWrite", "bvalid after bready", 0, bvalid);
    endtask

    task automatic setupChannel(input int ch, input int start, input int count,
                                input int loopS, input int loopE, input int loop,
                                input int vol, input int mono, input int right);
        chStart[ch] = start;
        chCount[ch] = count;
        chLoopS[ch] = loopS;
        chLoopE[ch] = loopE;
        chLoop[ch]  = loop;
        chVol[ch]   = vol;
        chMono[ch]  = mono;
        chRight[ch] = right;
        cpuWrite(regChannelSelect, 32'(1 << ch));
        cpuWrite(regStartAddr, start);
        cpuWrite(regSampleCount, count);
        cpuWrite(regLoopStart, loopS);
        cpuWrite(regLoopEnd, loopE);
        cpuWrite(regPosition, 0);
        cpuWrite(regVolume, vol);
        cpuWrite(regLooping, loop);
        cpuWrite(regMono, mono);
        cpuWrite(regRight, right);
    endtask

    task automatic setMaster(input int vol);
        masterVol = vol;
        cpuWrite(regGlobalVolume, vol);
    endtask

    task automatic buildExpected(input logic [3:0] mask, input int nFrames);
        int pos [4];
        int alive [4];
        int smp;
        int s;
        int left;
        int right;
        expFrames.delete();
        for (int ch = 0; ch < 4; ch++) begin
            pos[ch]   = 0;
            alive[ch] = 1;
        end
        for (int f = 0; f < nFrames; f++) begin
            left  = 0;
            right = 0;
            for (int ch = 0; ch < 4; ch++) begin
                if (mask[ch] && alive[ch] != 0) begin
                    smp = int'(memHalf(chStart[ch] + pos[ch]));
                    // One-shot stop mutes the last fetched sample
                    if (chLoop[ch] == 0 && pos[ch] + 1 >= chCount[ch]) begin
                        alive[ch] = 0;
                        smp = 0;
                    end else if (chLoop[ch] != 0 && pos[ch] + 1 >= chLoopE[ch]) begin
                        pos[ch] = chLoopS[ch];
                    end else begin
                        pos[ch]++;
                    end
                    s = (smp * chVol[ch]) >>> 7;
                    if (chMono[ch] != 0 || chRight[ch] == 0) left += s;
                    if (chMono[ch] != 0 || chRight[ch] != 0) right += s;
                end
            end
            left  = saturate((left * masterVol) >>> 7);
            right = saturate((right * masterVol) >>> 7);
            expFrames.push_back({left[15:0], right[15:0]});
        end
    endtask

    // Start at a quiet point of the frame so all channels join the same round
    task automatic playAndCheck(input string name, input logic [3:0] mask, input int nFrames);
        int j;
        buildExpected(mask, nFrames);
        @(negedge lrclk);
        repeat (16) @(posedge aclk);
        #2;
        frames.delete();
        cpuWrite(regChannelSelect, 32'(mask));
        cpuWrite(regPlaying, 1);
        while (frames.size() < nFrames + 4) @(posedge aclk);
        j = 0;
        while (j < 4 && frames[j] !== expFrames[0]) j++;
        assert (j < 4) else begin
            failRun($sformatf("%s: no output frame matched the first expected frame", name));
        end
        for (int k = 0; k < nFrames; k++) begin
            checkValue(name, $sformatf("frame %0d", k), expFrames[k], frames[j + k]);
        end
        cpuWrite(regChannelSelect, 32'hf);
        cpuWrite(regPlaying, 0);
    endtask

    // ########################################################################
    // Directed tests
    // ########################################################################
    task automatic testRegisterWrites;
        // Audible channel 1 that an empty mask must leave stopped
        setupChannel(1, 60, 50, 0, 0, 0, 128, 1, 0);
        cpuWrite(regChannelSelect, 32'h0);
        cpuWrite(regPlaying, 1);
        frames.delete();
        while (frames.size() < 5) @(posedge aclk);
        for (int k = 2; k < 5; k++) begin
            checkValue("testRegisterWrites", "silent frame", 0, frames[k]);
        end
    endtask

    task automatic testOneShotMono;
        setupChannel(0, 5, 6, 0, 0, 0, 128, 1, 0);
        playAndCheck("testOneShotMono", 4'b0001, 8);
    endtask

    task automatic testPanVolume;
        setupChannel(1, 40, 5, 0, 0, 0, 64, 0, 1);
        playAndCheck("testPanVolume", 4'b0010, 6);
    endtask

    task automatic testLooping;
        setupChannel(2, 100, 100, 2, 5, 1, 128, 1, 0);
        playAndCheck("testLooping", 4'b0100, 11);
    endtask

    task automatic testMixSaturate;
        setupChannel(0, 10, 20, 0, 0, 0, 128, 1, 0);
        setupChannel(1, 20, 20, 0, 0, 0, 128, 1, 0);
        setMaster(64);
        playAndCheck("testMixHalf", 4'b0011, 6);
        // First frame stays in range so it marks the start
        mem[60] = {16'h7000, 16'h0123};
        mem[61] = {16'h9000, 16'h8800};
        setupChannel(0, 120, 5, 0, 0, 0, 128, 1, 0);
        setupChannel(1, 120, 5, 0, 0, 0, 128, 1, 0);
        setMaster(255);
        playAndCheck("testMixClip", 4'b0011, 4);
        setMaster(128);
    endtask

    task automatic testBackPressure;
        setupChannel(0, 7, 30, 0, 0, 0, 100, 1, 0);
        setupChannel(1, 33, 30, 0, 0, 0, 128, 0, 1);
        setupChannel(2, 70, 30, 0, 0, 0, 90, 0, 0);
        setupChannel(3, 151, 30, 1, 4, 1, 50, 1, 0);
        playAndCheck("testBackPressure", 4'b1111, 12);
    endtask

    initial begin
        void'($urandom(32'h4d87));
        for (int a = 0; a < 256; a++) begin
            mem[a] = $urandom();
        end
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        shiftIn   = '0;
        prevLr    = 1'b0;
        masterVol = 128;
        @(posedge aresetn);
        testRegisterWrites();
        testOneShotMono();
        testPanVolume();
        testLooping();
        testMixSaturate();
        testBackPressure();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+rtl
rtl/audioRegPkg.sv
rtl/audioSamplePkg.sv
rtl/regInterface.sv
rtl/voiceChannel.sv
rtl/sampleFetcher.sv
rtl/stereoMixer.sv
rtl/i2sSerializer.sv
rtl/audioSystem.sv
sim/tbClock.sv
sim/tbAudio.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the audio engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tbAudio -o simAudio
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/simAudio 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    exit 1
fi

if echo "$output" | grep -Fxq "test passed"; then
    exit 0
fi
exit 1
